// ==== compile.f ====
spiPkg.sv
spiCtrlIf.sv
spiCsr.sv
spiMaster.sv
spiSlave.sv
spiTop.sv
tbSpiTop.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert --top-module tbSpiTop -f compile.f -o simv || exit 1
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== spiCsr.sv ====
`timescale 1ns/1ps

// --------------------------------------------------------------------------
// Master side register block and SCK divider
// --------------------------------------------------------------------------
module spiCsr
	import spiPkg::*;
#(
	parameter int divWidth = 8
)
(
	input  logic       iSysClk,
	input  logic       rstN,
	// Register port, read is combinational
	input  logic       regWe,
	input  logic [2:0] regAdr,
	input  spiWordT    regWd,
	output spiWordT    regRd,
	// Chip select level for the master role
	output logic       csOut,
	spiCtrlIf.csrSide  ctrl
);

	logic                spiEnR;
	logic                csLevel;
	logic                doneFlag;
	logic [divWidth-1:0] divReg;
	logic [divWidth-1:0] divCnt;
	logic                tickHit;
	logic                ctrlWe;
	spiByteT             txReg;
	spiByteT             rxReg;

	assign ctrlWe  = regWe && (regAdr == regCtrl);
	// Divider wraps at the programmed value
	assign tickHit = (divCnt == divReg);

	// Control state
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			spiEnR   <= 1'b0;
			csLevel  <= 1'b1;
			doneFlag <= 1'b0;
			divReg   <= divWidth'(3);
			divCnt   <= '0;
		end
		else
		begin
			// Run ends on byteDone
			// start bit has no effect in the same cycle
			if (ctrl.byteDone)
				spiEnR <= 1'b0;
			else if (ctrlWe && regWd[0])
				spiEnR <= 1'b1;

			// CS level follows bit 1 of every control write
			if (ctrlWe)
				csLevel <= regWd[1];

			if (regWe && (regAdr == regDiv))
				divReg <= regWd[divWidth-1:0];

			// Sticky done, cleared by loading the next byte
			if (ctrl.byteDone)
				doneFlag <= 1'b1;
			else if (regWe && (regAdr == regTx))
				doneFlag <= 1'b0;

			// Counter idles at zero between runs
			if (!spiEnR || tickHit)
				divCnt <= '0;
			else
				divCnt <= divCnt + 1'b1;
		end
	end

	// Byte registers
	always_ff @(posedge iSysClk)
	begin
		if (regWe && (regAdr == regTx))
			txReg <= regWd[7:0];
		if (ctrl.byteDone)
			rxReg <= ctrl.rxByte;
	end

	// Register read mux
	always_comb
	begin
		case (regAdr)
			regCtrl:   regRd = {30'd0, csLevel, spiEnR};
			regDiv:    regRd = spiWordT'(divReg);
			regTx:     regRd = spiWordT'(txReg);
			regRx:     regRd = spiWordT'(rxReg);
			regStatus: regRd = {30'd0, spiEnR, doneFlag};
			default:   regRd = '0;
		endcase
	end

	assign csOut       = csLevel;
	assign ctrl.spiEn  = spiEnR;
	assign ctrl.txByte = txReg;
	// One tick per divider period, only during a run
	assign ctrl.divCke = spiEnR && tickHit;

	// Master reports completion only inside a run
	doneInRun: assert property (@(posedge iSysClk) disable iff (!rstN)
		ctrl.byteDone |-> ctrl.spiEn);

endmodule

// ==== spiCtrlIf.sv ====
`timescale 1ns/1ps

// --------------------------------------------------------------------------
// Register block to master engine link
// --------------------------------------------------------------------------
interface spiCtrlIf
	import spiPkg::*;
();

	// Run enable, held until the byte completes
	logic    spiEn;
	// Divided clock tick, one cycle wide
	logic    divCke;
	// Byte to shift out on MOSI
	spiByteT txByte;
	// Byte collected from MISO
	spiByteT rxByte;
	// End of byte, one cycle wide
	logic    byteDone;

	modport csrSide
	(
		output spiEn,
		output divCke,
		output txByte,
		input  rxByte,
		input  byteDone
	);

	modport masterSide
	(
		input  spiEn,
		input  divCke,
		input  txByte,
		output rxByte,
		output byteDone
	);

endinterface

// ==== spiMaster.sv ====
`timescale 1ns/1ps

// --------------------------------------------------------------------------
// Mode 0 master, one byte per run
// --------------------------------------------------------------------------
module spiMaster
	import spiPkg::*;
#(
	parameter int holdCycles = 2
)
(
	input  logic         iSysClk,
	input  logic         rstN,
	output logic         sckOut,
	output logic         mosiOut,
	input  logic         misoIn,
	spiCtrlIf.masterSide ctrl
);

	localparam int holdW = $clog2(holdCycles + 1);

	// MOSI hold after each falling SCK
	typedef enum logic
	{
		holdIdle = 1'b0,
		holdWait = 1'b1
	} holdStateE;

	logic             sckR;
	logic [2:0]       negCnt;
	holdStateE        holdState;
	logic [holdW-1:0] holdCnt;
	logic             holdDone;
	logic             sckStep;
	logic             sckFall;
	logic             sckRise;
	logic             byteDoneR;
	spiByteT          txSh;
	spiByteT          rxSh;

	// No SCK edge in the cycle after the last fall
	assign sckStep  = ctrl.divCke && !byteDoneR;
	assign sckFall  = sckStep && sckR;
	assign sckRise  = sckStep && !sckR;
	assign holdDone = (holdState == holdWait) && (holdCnt == holdW'(holdCycles - 1));

	// ----------------------------------------------------------------------
	// SCK, edge count, hold FSM
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN || !ctrl.spiEn)
		begin
			sckR      <= 1'b0;
			negCnt    <= '0;
			holdState <= holdIdle;
			holdCnt   <= '0;
			byteDoneR <= 1'b0;
		end
		else
		begin
			if (sckStep)
				sckR <= !sckR;

			// Falling edges of the byte, wraps after eight
			if (sckFall)
				negCnt <= negCnt + 3'd1;

			case (holdState)
				holdIdle:
				begin
					holdCnt <= '0;
					if (sckFall)
						holdState <= holdWait;
				end
				holdWait:
				begin
					if (holdDone)
					begin
						holdState <= holdIdle;
						holdCnt   <= '0;
					end
					else
						holdCnt <= holdCnt + 1'b1;
				end
				default:
					holdState <= holdIdle;
			endcase

			// Eighth fall closes the byte
			byteDoneR <= sckFall && (negCnt == 3'd7);
		end
	end

	// ----------------------------------------------------------------------
	// Shift registers
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		// MSB waits on MOSI before the first rising edge
		if (!ctrl.spiEn)
			txSh <= ctrl.txByte;
		else if (holdDone)
			txSh <= {txSh[6:0], 1'b1};

		// MISO sampled on rising SCK
		if (sckRise)
			rxSh <= {rxSh[6:0], misoIn};
	end

	assign sckOut        = sckR;
	assign mosiOut       = txSh[7];
	assign ctrl.rxByte   = rxSh;
	assign ctrl.byteDone = byteDoneR;

	// Clock parks low once the register block drops the run
	sckIdleLow: assert property (@(posedge iSysClk) disable iff (!rstN)
		!ctrl.spiEn |-> !sckOut);

endmodule

// ==== spiPkg.sv ====
// --------------------------------------------------------------------------
// Shared types for the SPI port
// --------------------------------------------------------------------------
package spiPkg;

	// Slave address, data and reply word
	typedef logic [31:0] spiWordT;

	// One master transfer byte
	typedef logic [7:0] spiByteT;

	// Header length field, low half of the second header word
	typedef logic [15:0] spiLenT;

	// Header command, bits 17:16 of the second header word
	typedef enum logic [1:0]
	{
		cmdNone     = 2'd0,
		cmdCsrWrite = 2'd1,
		cmdCsrRead  = 2'd2,
		cmdMemWrite = 2'd3
	} spiCmdE;

	// Slave receive sequence
	// Address word, then command word, then data words until CS rises
	typedef enum logic [1:0]
	{
		stAdrsGet = 2'd0,
		stCmdGet  = 2'd1,
		stDataGet = 2'd2
	} slvStateE;

	// Register map of the master side
	localparam logic [2:0] regCtrl   = 3'd0;
	localparam logic [2:0] regDiv    = 3'd1;
	localparam logic [2:0] regTx     = 3'd2;
	localparam logic [2:0] regRx     = 3'd3;
	localparam logic [2:0] regStatus = 3'd4;

endpackage

// ==== spiSlave.sv ====
`timescale 1ns/1ps

// --------------------------------------------------------------------------
// Mode 0 slave receiver
// 8 byte header, then 32 bit data words until CS rises
// --------------------------------------------------------------------------
module spiSlave
	import spiPkg::*;
(
	input  logic    iSysClk,
	input  logic    rstN,
	// High while the port plays slave
	input  logic    active,
	input  logic    sckIn,
	input  logic    mosiIn,
	input  logic    csIn,
	output logic    misoOut,
	input  spiWordT replyWord,
	output spiWordT rdWord,
	output spiWordT adrs,
	output spiCmdE  cmd,
	output spiLenT  dLen,
	output logic    rdEd
);

	logic [2:0] sckSync;
	logic [2:0] mosiSync;
	logic [2:0] csSync;
	logic       csLow;
	logic       sckRise;
	logic       sckFall;
	logic       wordEnd;
	logic [4:0] negCnt;
	slvStateE   state;
	spiWordT    rxSh;
	spiWordT    replySh;
	spiWordT    adrsR;
	spiCmdE     cmdR;
	spiLenT     dLenR;
	logic       rdEdR;

	// ----------------------------------------------------------------------
	// Pin synchronizers, held idle outside the slave role
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN || !active)
		begin
			sckSync  <= '0;
			mosiSync <= '0;
			csSync   <= '1;
		end
		else
		begin
			sckSync  <= {sckSync[1:0], sckIn};
			mosiSync <= {mosiSync[1:0], mosiIn};
			csSync   <= {csSync[1:0], csIn};
		end
	end

	assign csLow   = !csSync[2];
	// Edges only count while selected
	assign sckRise = csLow && (sckSync[2:1] == 2'b01);
	assign sckFall = csLow && (sckSync[2:1] == 2'b10);
	// Last bit of the current 32 bit word
	assign wordEnd = (negCnt == 5'd31);

	// ----------------------------------------------------------------------
	// Sequence control
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			state  <= stAdrsGet;
			negCnt <= '0;
			rdEdR  <= 1'b0;
			cmdR   <= cmdNone;
			dLenR  <= '0;
		end
		else
		begin
			if (!csLow)
				negCnt <= '0;
			else if (sckFall)
				negCnt <= negCnt + 5'd1;

			// Data phase lasts until CS rises
			if (!csLow)
				state <= stAdrsGet;
			else if (sckFall && wordEnd)
			begin
				case (state)
					stAdrsGet: state <= stCmdGet;
					stCmdGet:  state <= stDataGet;
					default:   state <= stDataGet;
				endcase
			end

			// Word strobe at the 32nd rising edge
			rdEdR <= sckRise && wordEnd && (state == stDataGet);

			// Command and length, valid through the data phase
			if (sckFall && wordEnd && (state == stCmdGet))
			begin
				cmdR  <= spiCmdE'(rxSh[17:16]);
				dLenR <= rxSh[15:0];
			end
			else if (state != stDataGet)
			begin
				cmdR  <= cmdNone;
				dLenR <= '0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// Data path
	// ----------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		// MOSI in, MSB first
		if (sckRise)
			rxSh <= {rxSh[30:0], mosiSync[2]};

		// Start address, then one step per data word
		if (sckFall && wordEnd)
		begin
			if (state == stAdrsGet)
				adrsR <= rxSh;
			else if (state == stDataGet)
				adrsR <= adrsR + 32'd1;
		end

		// Reply reloads at every word boundary
		if ((state != stDataGet) || (sckFall && wordEnd))
			replySh <= replyWord;
		else if (sckFall)
			replySh <= {replySh[30:0], 1'b0};
	end

	assign misoOut = replySh[31];
	assign rdWord  = rxSh;
	assign adrs    = adrsR;
	assign cmd     = cmdR;
	assign dLen    = dLenR;
	assign rdEd    = rdEdR;

	// Strobes belong to the data phase only
	rdEdInData: assert property (@(posedge iSysClk) disable iff (!rstN)
		rdEdR |-> (state == stDataGet));

	// Deselect restarts the header
	csHighIdle: assert property (@(posedge iSysClk) disable iff (!rstN)
		!csLow |=> (state == stAdrsGet) && (negCnt == '0));

endmodule

// ==== spiTop.sv ====
`timescale 1ns/1ps

// --------------------------------------------------------------------------
// SPI port top, master or slave by msSel
// Pads split into in, out and enable
// --------------------------------------------------------------------------
module spiTop
	import spiPkg::*;
#(
	parameter int divWidth   = 8,
	parameter int holdCycles = 2
)
(
	input  logic       iSysClk,
	input  logic       rstN,
	// High selects the slave role
	input  logic       msSel,
	input  logic       sckIn,
	output logic       sckOut,
	output logic       sckOe,
	input  logic       mosiIn,
	output logic       mosiOut,
	output logic       mosiOe,
	input  logic       misoIn,
	output logic       misoOut,
	output logic       misoOe,
	input  logic       csIn,
	output logic       csOut,
	output logic       csOe,
	output logic       wpOut,
	output logic       holdOut,
	output logic       wpHoldOe,
	// Master register port
	input  logic       regWe,
	input  logic [2:0] regAdr,
	input  spiWordT    regWd,
	output spiWordT    regRd,
	// Slave side
	input  spiWordT    replyWord,
	output spiWordT    rdWord,
	output spiWordT    adrs,
	output spiCmdE     cmd,
	output spiLenT     dLen,
	output logic       rdEd
);

	logic [2:0] msSync;
	logic       slaveMode;

	spiCtrlIf ctrlBus ();

	// Role synchronizer, comes out of reset as slave
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			msSync <= 3'b111;
		else
			msSync <= {msSync[1:0], msSel};
	end

	assign slaveMode = msSync[2];

	// Pad enables
	assign sckOe    = !slaveMode;
	assign mosiOe   = !slaveMode;
	assign csOe     = !slaveMode;
	assign wpHoldOe = !slaveMode;
	assign misoOe   = slaveMode;
	// WP and HOLD inactive
	assign wpOut    = 1'b1;
	assign holdOut  = 1'b1;

	spiCsr #(
		.divWidth (divWidth)
	) i_spiCsr (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.regWe   (regWe),
		.regAdr  (regAdr),
		.regWd   (regWd),
		.regRd   (regRd),
		.csOut   (csOut),
		.ctrl    (ctrlBus.csrSide)
	);

	spiMaster #(
		.holdCycles (holdCycles)
	) i_spiMaster (
		.iSysClk (iSysClk),
		.rstN    (rstN),
		.sckOut  (sckOut),
		.mosiOut (mosiOut),
		.misoIn  (misoIn),
		.ctrl    (ctrlBus.masterSide)
	);

	spiSlave i_spiSlave (
		.iSysClk   (iSysClk),
		.rstN      (rstN),
		.active    (slaveMode),
		.sckIn     (sckIn),
		.mosiIn    (mosiIn),
		.csIn      (csIn),
		.misoOut   (misoOut),
		.replyWord (replyWord),
		.rdWord    (rdWord),
		.adrs      (adrs),
		.cmd       (cmd),
		.dLen      (dLen),
		.rdEd      (rdEd)
	);

endmodule

// ==== tbSpiTop.sv ====
`timescale 1ns/1ps

module tbSpiTop
	import spiPkg::*;
();

	localparam int numFrames     = 2;
	localparam int wordsPerFrame = 3;
	localparam int numBytes      = 3;
	// Slave frames plus master bytes, 16 clocks per bit, margin of four
	localparam int totalBits  = numFrames * (64 + wordsPerFrame * 32) + numBytes * 8;
	localparam int cycleLimit = 4 * totalBits * 16;

	logic       iSysClk = 1'b0;
	logic       rstN;
	logic       msSel;
	logic       sckIn, sckOut, sckOe;
	logic       mosiIn, mosiOut, mosiOe;
	logic       misoIn, misoOut, misoOe;
	logic       csIn, csOut, csOe;
	logic       wpOut, holdOut, wpHoldOe;
	logic       regWe;
	logic [2:0] regAdr;
	spiWordT    regWd;
	spiWordT    regRd;
	spiWordT    replyWord;
	spiWordT    rdWord;
	spiWordT    adrs;
	spiCmdE     cmd;
	spiLenT     dLen;
	logic       rdEd;

	// Expected slave results, filled by refFrame
	spiWordT    expWordQ[$];
	spiWordT    expAdrsQ[$];
	logic       expReplyQ[$];
	spiCmdE     expCmd;
	spiLenT     expLen;
	int         cmpIdx   = 0;
	int         cycleCnt = 0;
	logic       idleChk  = 1'b0;
	logic [31:0] rngState = 32'd57;

	always #4 iSysClk = ~iSysClk;

	spiTop #(
		.divWidth   (8),
		.holdCycles (2)
	) i_spiTop (
		.iSysClk (iSysClk), .rstN (rstN), .msSel (msSel),
		.sckIn (sckIn), .sckOut (sckOut), .sckOe (sckOe),
		.mosiIn (mosiIn), .mosiOut (mosiOut), .mosiOe (mosiOe),
		.misoIn (misoIn), .misoOut (misoOut), .misoOe (misoOe),
		.csIn (csIn), .csOut (csOut), .csOe (csOe),
		.wpOut (wpOut), .holdOut (holdOut), .wpHoldOe (wpHoldOe),
		.regWe (regWe), .regAdr (regAdr), .regWd (regWd), .regRd (regRd),
		.replyWord (replyWord), .rdWord (rdWord), .adrs (adrs),
		.cmd (cmd), .dLen (dLen), .rdEd (rdEd)
	);

	// --------------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------------
	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "Stopped at first error");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] drawRand();
		rngState = xorshift(rngState);
		return rngState;
	endfunction

	// Expected fields, words, addresses and MISO bits of one slave frame
	function automatic void refFrame(input spiWordT hdrAdrs, input spiWordT hdrCmdLen,
		input spiWordT words [wordsPerFrame], input spiWordT reply);
		// Command in bits 17:16, length in the low half
		expCmd = spiCmdE'(hdrCmdLen[17:16]);
		expLen = hdrCmdLen[15:0];
		for (int k = 0; k < wordsPerFrame; k++)
		begin
			expWordQ.push_back(words[k]);
			// One address step per completed word
			expAdrsQ.push_back(hdrAdrs + spiWordT'(k));
			// Same reply word for every data word, MSB first
			for (int b = 31; b >= 0; b--)
				expReplyQ.push_back(reply[b]);
		end
	endfunction

	task automatic regWrite(input logic [2:0] adr, input spiWordT val);
		@(posedge iSysClk);
		regWe  <= 1'b1;
		regAdr <= adr;
		regWd  <= val;
		@(posedge iSysClk);
		regWe  <= 1'b0;
		// Status stays on the read port between accesses
		regAdr <= regStatus;
	endtask

	task automatic regRead(input logic [2:0] adr, output spiWordT val);
		@(posedge iSysClk);
		regAdr <= adr;
		@(negedge iSysClk);
		val = regRd;
	endtask

	// Pad enables for the given role
	task automatic checkRole(input logic slave);
		@(negedge iSysClk);
		assert (sckOe == !slave)
		else
			stopOnError($sformatf("Fail sckOe got 0x%0h expected 0x%0h", sckOe, !slave));
		assert (mosiOe == !slave)
		else
			stopOnError($sformatf("Fail mosiOe got 0x%0h expected 0x%0h", mosiOe, !slave));
		assert (csOe == !slave)
		else
			stopOnError($sformatf("Fail csOe got 0x%0h expected 0x%0h", csOe, !slave));
		assert (misoOe == slave)
		else
			stopOnError($sformatf("Fail misoOe got 0x%0h expected 0x%0h", misoOe, slave));
		assert (wpHoldOe == !slave)
		else
			stopOnError($sformatf("Fail wpHoldOe got 0x%0h expected 0x%0h", wpHoldOe, !slave));
		// WP and HOLD inactive high
		assert (wpOut == 1'b1)
		else
			stopOnError($sformatf("Fail wpOut got 0x%0h expected 0x1", wpOut));
		assert (holdOut == 1'b1)
		else
			stopOnError($sformatf("Fail holdOut got 0x%0h expected 0x1", holdOut));
	endtask

	// --------------------------------------------------------------------------
	// External master model, 8 clocks per SCK half period
	// --------------------------------------------------------------------------
	task automatic sendWord(input spiWordT w, input logic inData);
		logic expBit;
		for (int i = 31; i >= 0; i--)
		begin
			@(posedge iSysClk);
			sckIn  <= 1'b0;
			mosiIn <= w[i];
			repeat (7) @(posedge iSysClk);
			// MISO just before the rising edge
			@(negedge iSysClk);
			if (inData)
			begin
				expBit = expReplyQ.pop_front();
				assert (misoOut == expBit)
				else
					stopOnError($sformatf("Fail misoOut got 0x%0h expected 0x%0h", misoOut, expBit));
			end
			@(posedge iSysClk);
			sckIn <= 1'b1;
			repeat (7) @(posedge iSysClk);
		end
	endtask

	task automatic sendFrame(input spiWordT hdrAdrs, input spiWordT hdrCmdLen,
		input spiWordT words [wordsPerFrame]);
		@(posedge iSysClk);
		csIn <= 1'b0;
		repeat (8) @(posedge iSysClk);
		sendWord(hdrAdrs, 1'b0);
		sendWord(hdrCmdLen, 1'b0);
		for (int k = 0; k < wordsPerFrame; k++)
			sendWord(words[k], 1'b1);
		// Closing falling edge, then deselect
		@(posedge iSysClk);
		sckIn <= 1'b0;
		repeat (8) @(posedge iSysClk);
		csIn <= 1'b1;
		repeat (8) @(posedge iSysClk);
	endtask

	// --------------------------------------------------------------------------
	// Master run with an external slave model answering rxB
	// --------------------------------------------------------------------------
	task automatic masterByte(input spiByteT txB, input spiByteT rxB, input spiWordT divVal);
		spiByteT mosiSeen;
		spiWordT rdVal;
		int      riseCnt;
		int      fallCnt;
		logic    prevSck;
		logic    fell;
		logic    done;
		mosiSeen = '0;
		riseCnt  = 0;
		fallCnt  = 0;
		prevSck  = 1'b0;
		done     = 1'b0;
		regWrite(regDiv, divVal);
		regWrite(regTx, spiWordT'(txB));
		// MSB ready before the first rising edge
		@(posedge iSysClk);
		misoIn <= rxB[7];
		// Start, CS level low
		regWrite(regCtrl, 32'h1);
		while (!done)
		begin
			@(negedge iSysClk);
			fell = prevSck && !sckOut;
			if (!prevSck && sckOut)
			begin
				if (riseCnt < 8)
					mosiSeen[7 - riseCnt] = mosiOut;
				riseCnt++;
			end
			if (fell)
				fallCnt++;
			prevSck = sckOut;
			done    = regRd[0];
			@(posedge iSysClk);
			// Next MISO bit after each falling edge
			if (fell && (fallCnt < 8))
				misoIn <= rxB[7 - fallCnt];
		end
		assert ((riseCnt == 8) && (fallCnt == 8))
		else
			stopOnError($sformatf("Wrong SCK edge count, %0d rises and %0d falls", riseCnt, fallCnt));
		assert (mosiSeen == txB)
		else
			stopOnError($sformatf("Fail mosiOut got 0x%02h expected 0x%02h", mosiSeen, txB));
		regRead(regRx, rdVal);
		assert (rdVal[7:0] == rxB)
		else
			stopOnError($sformatf("Fail regRx got 0x%02h expected 0x%02h", rdVal[7:0], rxB));
		assert (csOut == 1'b0)
		else
			stopOnError($sformatf("Fail csOut got 0x%0h expected 0x0", csOut));
		regRead(regStatus, rdVal);
		assert (rdVal[1:0] == 2'b01)
		else
			stopOnError($sformatf("Fail regStatus got 0x%0h expected 0x1", rdVal[1:0]));
		// Raise CS without a new start
		regWrite(regCtrl, 32'h2);
		@(negedge iSysClk);
		assert (csOut == 1'b1)
		else
			stopOnError($sformatf("Fail csOut got 0x%0h expected 0x1", csOut));
	endtask

	// --------------------------------------------------------------------------
	// Compare, idle watch and timeout
	// --------------------------------------------------------------------------
	always @(negedge iSysClk)
	begin
		if (rstN && rdEd)
		begin
			assert (cmpIdx < expWordQ.size())
			else
				stopOnError("rdEd pulsed with no data word outstanding");
			if (cmpIdx < expWordQ.size())
			begin
				assert (rdWord == expWordQ[cmpIdx])
				else
					stopOnError($sformatf("Fail rdWord got 0x%08h expected 0x%08h",
						rdWord, expWordQ[cmpIdx]));
				assert (adrs == expAdrsQ[cmpIdx])
				else
					stopOnError($sformatf("Fail adrs got 0x%08h expected 0x%08h",
						adrs, expAdrsQ[cmpIdx]));
				// Header fields held through the data phase
				assert (cmd == expCmd)
				else
					stopOnError($sformatf("Fail cmd got 0x%0h expected 0x%0h", cmd, expCmd));
				assert (dLen == expLen)
				else
					stopOnError($sformatf("Fail dLen got 0x%04h expected 0x%04h", dLen, expLen));
				cmpIdx = cmpIdx + 1;
			end
		end
	end

	// Master pins quiet in the slave role
	always @(negedge iSysClk)
	begin
		if (idleChk)
		begin
			assert (sckOut == 1'b0)
			else
				stopOnError($sformatf("Fail sckOut got 0x%0h expected 0x0", sckOut));
			assert (csOut == 1'b1)
			else
				stopOnError($sformatf("Fail csOut got 0x%0h expected 0x1", csOut));
		end
	end

	always @(posedge iSysClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= cycleLimit)
		begin
			$display("Run timed out after %0d cycles", cycleCnt);
			$display("Done: errors found");
			$fatal(1, "Timeout");
		end
	end

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------
	initial
	begin
		spiWordT hdrAdrs;
		spiWordT hdrCmdLen;
		spiWordT reply;
		spiWordT words [wordsPerFrame];
		spiByteT txB;
		spiByteT rxB;
		rstN      = 1'b0;
		msSel     = 1'b1;
		sckIn     = 1'b0;
		mosiIn    = 1'b0;
		misoIn    = 1'b0;
		csIn      = 1'b1;
		regWe     = 1'b0;
		regAdr    = regStatus;
		regWd     = '0;
		replyWord = '0;
		repeat (8) @(posedge iSysClk);
		rstN <= 1'b1;
		repeat (4) @(posedge iSysClk);

		// Slave role, header decode, data words and reply
		checkRole(1'b1);
		idleChk = 1'b1;
		for (int f = 0; f < numFrames; f++)
		begin
			hdrAdrs   = drawRand();
			hdrCmdLen = drawRand();
			reply     = drawRand();
			for (int k = 0; k < wordsPerFrame; k++)
				words[k] = drawRand();
			@(posedge iSysClk);
			replyWord <= reply;
			refFrame(hdrAdrs, hdrCmdLen, words, reply);
			sendFrame(hdrAdrs, hdrCmdLen, words);
			assert ((cmpIdx == expWordQ.size()) && (expReplyQ.size() == 0))
			else
				stopOnError($sformatf("Frame %0d ended with %0d of %0d data strobes",
					f, cmpIdx, expWordQ.size()));
		end
		idleChk = 1'b0;

		// Master role, one byte per run
		@(posedge iSysClk);
		msSel <= 1'b0;
		repeat (4) @(posedge iSysClk);
		checkRole(1'b0);
		for (int b = 0; b < numBytes; b++)
		begin
			txB = spiByteT'(drawRand());
			rxB = spiByteT'(drawRand());
			masterByte(txB, rxB, spiWordT'(2 + (drawRand() % 4)));
		end

		// Back to slave, pins stay idle
		@(posedge iSysClk);
		msSel <= 1'b1;
		repeat (4) @(posedge iSysClk);
		checkRole(1'b1);
		idleChk = 1'b1;
		repeat (32) @(posedge iSysClk);
		idleChk = 1'b0;

		$display("Done: no errors");
		$finish;
	end

endmodule
